// ==== bus_matrix/bus_decoder.sv ====
// Per-manager bus decoder: region decode, data-phase port tracking and return-path mux
module bus_decoder (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  matrix_pkg::addr_t   haddr,
  input  matrix_pkg::trans_t  htrans,
  input  logic                hreadys,      // Own HREADYOUTS fed back
  output logic                sel_dec0,
  output logic                sel_dec1,
  output logic                sel_dec2,
  input  logic                active0,
  input  logic                active1,
  input  logic                active2,
  input  logic                readyout0,
  input  logic                readyout1,
  input  logic                readyout2,
  input  matrix_pkg::resp_t   resp0,
  input  matrix_pkg::resp_t   resp1,
  input  matrix_pkg::resp_t   resp2,
  input  matrix_pkg::data_t   rdata0,
  input  matrix_pkg::data_t   rdata1,
  input  matrix_pkg::data_t   rdata2,
  output logic                hreadyouts,
  output matrix_pkg::resp_t   hresps,
  output matrix_pkg::data_t   hrdatas
);

  logic [matrix_pkg::REGION_BITS-1:0] region;
  matrix_pkg::port_sel_t addr_port;   // Port of the address phase
  matrix_pkg::port_sel_t data_port;   // Port owning the data phase
  logic dp_busy;                      // Real transfer in data phase
  logic is_nonseq;
  logic req;                          // Address phase may be issued
  logic active_sel;
  logic stall;                        // Request waiting for a grant
  logic dp_ready;
  matrix_pkg::resp_t dp_resp;

  // Local default subordinate
  logic sel_dflt;
  logic readyout_dflt;
  matrix_pkg::resp_t resp_dflt;

  default_slave u_default_slave (
    .HCLK      (HCLK),
    .HRESETn   (HRESETn),
    .hsel      (sel_dflt),
    .htrans    (htrans),
    .hready    (hreadys),
    .hreadyout (readyout_dflt),
    .hresp     (resp_dflt)
  );

  // ----------------------------------------------------------------------
  // Address phase
  // ----------------------------------------------------------------------
  assign region    = haddr[31 -: matrix_pkg::REGION_BITS];
  assign is_nonseq = htrans[1];   // SEQ counts as NONSEQ, BUSY as IDLE

  always_comb
  begin
    if (!is_nonseq)
      addr_port = data_port;      // IDLE keeps the last port
    else if (region < matrix_pkg::NUM_SUBS)
      addr_port = matrix_pkg::port_sel_t'(region);
    else
      addr_port = matrix_pkg::PORT_DFLT;
  end

  // No new request until the previous data phase completes
  assign req      = is_nonseq && dp_ready;
  assign sel_dec0 = req && (addr_port == 2'd0);
  assign sel_dec1 = req && (addr_port == 2'd1);
  assign sel_dec2 = req && (addr_port == 2'd2);
  assign sel_dflt = req && (addr_port == matrix_pkg::PORT_DFLT);

  always_comb
  begin
    case (addr_port)
      2'd0:    active_sel = active0;
      2'd1:    active_sel = active1;
      2'd2:    active_sel = active2;
      default: active_sel = 1'b1;   // Default subordinate never contended
    endcase
  end

  assign stall = req && !active_sel;

  // ----------------------------------------------------------------------
  // Data phase
  // ----------------------------------------------------------------------
  // hreadys is only high once the address phase has been accepted
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      data_port <= 2'd0;
      dp_busy   <= 1'b0;
    end
    else if (hreadys)
    begin
      data_port <= addr_port;
      dp_busy   <= is_nonseq;
    end
  end

  always_comb
  begin
    case (data_port)
      2'd0:
      begin
        dp_ready = readyout0;
        dp_resp  = resp0;
        hrdatas  = rdata0;
      end
      2'd1:
      begin
        dp_ready = readyout1;
        dp_resp  = resp1;
        hrdatas  = rdata1;
      end
      2'd2:
      begin
        dp_ready = readyout2;
        dp_resp  = resp2;
        hrdatas  = rdata2;
      end
      default:
      begin
        dp_ready = readyout_dflt;
        dp_resp  = resp_dflt;
        hrdatas  = '0;              // Default subordinate reads zero
      end
    endcase
    // Idle data phase, zero wait OKAY whatever the shared port does
    if (!dp_busy)
    begin
      dp_ready = 1'b1;
      dp_resp  = matrix_pkg::RESP_OKAY;
    end
  end

  assign hreadyouts = dp_ready && !stall;   // Stall extends the address phase
  assign hresps     = dp_resp;

endmodule

// ==== bus_matrix/output_stage.sv ====
// Per-subordinate output stage: round-robin arbiter and address/write-data mux
module output_stage (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  logic                req0,
  input  logic                req1,
  input  matrix_pkg::addr_t   haddr0,
  input  matrix_pkg::addr_t   haddr1,
  input  logic                hwrite0,
  input  logic                hwrite1,
  input  matrix_pkg::data_t   hwdata0,
  input  matrix_pkg::data_t   hwdata1,
  input  logic                hreadyout_sub,
  output logic                active0,
  output logic                active1,
  output logic                hsel,
  output matrix_pkg::addr_t   haddr,
  output matrix_pkg::trans_t  htrans,
  output logic                hwrite,
  output matrix_pkg::data_t   hwdata
);

  logic grant;        // Manager holding the address phase, last grant
  logic data_owner;   // Manager whose transfer is in the data phase
  logic req_holder;   // Grant holder is requesting
  logic req_other;    // The other manager is requesting

  assign req_holder = grant ? req1 : req0;
  assign req_other  = grant ? req0 : req1;

  // ----------------------------------------------------------------------
  // Arbitration
  // ----------------------------------------------------------------------
  // Grant moves on only at a ready edge. A waiting manager takes over
  // after the holder's transfer is accepted, or when the holder is idle
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      grant <= 1'b0;                // Manager 0 after reset
    else if (hreadyout_sub && req_other)
      grant <= ~grant;
  end

  // Owner follows the accepted address into its data phase
  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      data_owner <= 1'b0;
    else if (hreadyout_sub && req_holder)
      data_owner <= grant;
  end

  // Accept strobes back to the decoders
  assign active0 = hreadyout_sub && req0 && !grant;
  assign active1 = hreadyout_sub && req1 && grant;

  // ----------------------------------------------------------------------
  // Subordinate side mux
  // ----------------------------------------------------------------------
  assign hsel   = req_holder;
  assign htrans = req_holder ? matrix_pkg::TRANS_NONSEQ : matrix_pkg::TRANS_IDLE;
  assign haddr  = grant ? haddr1 : haddr0;
  assign hwrite = grant ? hwrite1 : hwrite0;

  // Write data belongs to the data phase, not the address phase
  assign hwdata = data_owner ? hwdata1 : hwdata0;

endmodule

// ==== common/matrix_pkg.sv ====
// Bus matrix package with the address map, bus widths, types and FSM encodings
package matrix_pkg;

  // ----------------------------------------------------------------------
  // Bus field types
  // ----------------------------------------------------------------------
  typedef logic [31:0] addr_t;      // HADDR
  typedef logic [31:0] data_t;      // HWDATA / HRDATA
  typedef logic [1:0]  trans_t;     // HTRANS
  typedef logic        resp_t;      // HRESP, AHB-Lite single bit
  typedef logic [1:0]  port_sel_t;  // Decoded output port, 3 is default subordinate

  // HTRANS codes, BUSY and SEQ fold onto these through bit 1
  localparam trans_t TRANS_IDLE   = 2'b00;
  localparam trans_t TRANS_NONSEQ = 2'b10;

  localparam resp_t RESP_OKAY  = 1'b0;
  localparam resp_t RESP_ERROR = 1'b1;

  // ----------------------------------------------------------------------
  // Address map
  // ----------------------------------------------------------------------
  // Top address bits pick a 512 MB region
  localparam int REGION_BITS = 3;
  localparam int NUM_SUBS    = 3;           // Regions 0..2 map to SRAMs
  localparam port_sel_t PORT_DFLT = 2'd3;   // Everything else

  // SRAM geometry, word addressed through haddr[9:2]
  localparam int SRAM_WORDS = 256;

  // Fixed wait states per SRAM
  localparam int WAIT_S0 = 0;
  localparam int WAIT_S1 = 1;
  localparam int WAIT_S2 = 2;

  // Default subordinate FSM
  typedef enum logic [1:0] {
    IDLE,   // OKAY, zero wait
    ERR1,   // First ERROR cycle, not ready
    ERR2    // Second ERROR cycle, ready
  } dflt_state_e;

endpackage

// ==== dv/matrix_checker.sv ====
// Bus monitor and scoreboard pairing each manager's accepted address with its data phase
module matrix_checker (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  matrix_pkg::addr_t   haddr_0,
  input  matrix_pkg::trans_t  htrans_0,
  input  logic                hwrite_0,
  input  matrix_pkg::data_t   hwdata_0,
  input  logic                hreadyout_0,
  input  matrix_pkg::resp_t   hresp_0,
  input  matrix_pkg::data_t   hrdata_0,
  input  matrix_pkg::addr_t   haddr_1,
  input  matrix_pkg::trans_t  htrans_1,
  input  logic                hwrite_1,
  input  matrix_pkg::data_t   hwdata_1,
  input  logic                hreadyout_1,
  input  matrix_pkg::resp_t   hresp_1,
  input  matrix_pkg::data_t   hrdata_1
);
  timeunit 1ns;
  timeprecision 100ps;

  localparam int HANG_LIMIT = 100;   // Cycles of low ready before a transfer counts as hung

  // One reference memory per mapped region
  matrix_pkg::data_t ref_mem [matrix_pkg::NUM_SUBS][matrix_pkg::SRAM_WORDS];

  logic              pend [2];        // Address accepted and data phase open
  matrix_pkg::addr_t pend_addr [2];
  logic              pend_write [2];
  int                stuck [2];       // Consecutive low-ready cycles
  int                errors = 0;
  int                completed = 0;   // Data phases seen to the end

  // ----------------------------------------------------------------------
  // Reference model
  // ----------------------------------------------------------------------
  function automatic logic is_mapped(input matrix_pkg::addr_t a);
    return (a[31:29] < 3'd3);   // Regions 0..2 are SRAMs
  endfunction

  // Default subordinate reads as zero
  function automatic matrix_pkg::data_t expected_rdata(input matrix_pkg::addr_t a);
    if (!is_mapped(a))
      return '0;
    return ref_mem[a[30:29]][a[9:2]];
  endfunction

  function automatic matrix_pkg::resp_t expected_resp(input matrix_pkg::addr_t a);
    return is_mapped(a) ? matrix_pkg::RESP_OKAY : matrix_pkg::RESP_ERROR;
  endfunction

  // Low-ready cycles in the data phase for each region
  function automatic int expected_waits(input matrix_pkg::addr_t a);
    case (a[31:29])
      3'd0:    return matrix_pkg::WAIT_S0;
      3'd1:    return matrix_pkg::WAIT_S1;
      3'd2:    return matrix_pkg::WAIT_S2;
      default: return 1;   // First ERROR cycle only
    endcase
  endfunction

  task automatic finish_transfer(input int m, input matrix_pkg::data_t wdata,
                                 input matrix_pkg::resp_t resp, input matrix_pkg::data_t rdata,
                                 input int waits);
    matrix_pkg::addr_t a;
    matrix_pkg::resp_t exp_resp;
    matrix_pkg::data_t exp_rdata;
    int                exp_waits;
    a         = pend_addr[m];
    exp_resp  = expected_resp(a);
    exp_rdata = expected_rdata(a);
    exp_waits = expected_waits(a);
    if (resp !== exp_resp)
    begin
      $display("ERROR %0d ns hresp_%0d expected %0b actual %0b", $time, m, exp_resp, resp);
      errors++;
    end
    if (!pend_write[m] && rdata !== exp_rdata)
    begin
      $display("ERROR %0d ns hrdata_%0d expected %08h actual %08h (addr %08h)",
               $time, m, exp_rdata, rdata, a);
      errors++;
    end
    if (waits != exp_waits)
    begin
      $display("ERROR %0d ns hreadyout_%0d wait states expected %0d actual %0d (addr %08h)",
               $time, m, exp_waits, waits, a);
      errors++;
    end
    if (pend_write[m] && is_mapped(a))
      ref_mem[a[30:29]][a[9:2]] = wdata;   // Unmapped writes leave SRAMs alone
    completed++;
  endtask

  // Samples one manager port in the middle of the cycle
  task automatic watch(input int m, input matrix_pkg::addr_t haddr,
                       input matrix_pkg::trans_t htrans, input logic hwrite,
                       input matrix_pkg::data_t hwdata, input logic ready,
                       input matrix_pkg::resp_t resp, input matrix_pkg::data_t rdata);
    if (!ready)
    begin
      stuck[m]++;
      // Wait cycles of a data phase already carry its response
      if (pend[m] && resp !== expected_resp(pend_addr[m]))
      begin
        $display("ERROR %0d ns hresp_%0d expected %0b actual %0b in a wait cycle",
                 $time, m, expected_resp(pend_addr[m]), resp);
        errors++;
      end
      if (stuck[m] == HANG_LIMIT)
      begin
        $display("Manager %0d has seen ready low for %0d cycles, transfer hung at %0d ns",
                 m, HANG_LIMIT, $time);
        errors++;
      end
    end
    else
    begin
      if (pend[m])
        finish_transfer(m, hwdata, resp, rdata, stuck[m]);
      stuck[m]      = 0;
      pend[m]       = htrans[1];   // NONSEQ accepted on this edge
      pend_addr[m]  = haddr;
      pend_write[m] = hwrite;
    end
  endtask

  // ----------------------------------------------------------------------
  // Compare process on the falling edge, clear of drive and update edges
  // ----------------------------------------------------------------------
  always @(negedge HCLK)
  begin
    if (!HRESETn)
    begin
      for (int m = 0; m < 2; m++)
      begin
        pend[m]  = 1'b0;
        stuck[m] = 0;
      end
    end
    else
    begin
      watch(0, haddr_0, htrans_0, hwrite_0, hwdata_0, hreadyout_0, hresp_0, hrdata_0);
      watch(1, haddr_1, htrans_1, hwrite_1, hwdata_1, hreadyout_1, hresp_1, hrdata_1);
    end
  end

endmodule

// ==== dv/tb_matrix_subsystem.sv ====
// Testbench top for the bus matrix: clock, reset, random stimulus and two manager drivers
module tb_matrix_subsystem;
  timeunit 1ns;
  timeprecision 100ps;

  localparam int TIMEOUT = 200;   // Cycles per wait for ready
  localparam int MIX_LEN = 150;   // Random transfers per manager
  localparam int POOL    = 16;    // Words per region that get filled first

  logic               HCLK;
  logic               HRESETn;
  matrix_pkg::addr_t  haddr_0;
  matrix_pkg::trans_t htrans_0;
  logic               hwrite_0;
  matrix_pkg::data_t  hwdata_0;
  logic               hreadyout_0;
  matrix_pkg::resp_t  hresp_0;
  matrix_pkg::data_t  hrdata_0;
  matrix_pkg::addr_t  haddr_1;
  matrix_pkg::trans_t htrans_1;
  logic               hwrite_1;
  matrix_pkg::data_t  hwdata_1;
  logic               hreadyout_1;
  matrix_pkg::resp_t  hresp_1;
  matrix_pkg::data_t  hrdata_1;

  logic [31:0] lfsr;
  int          tb_errors = 0;
  int          issued = 0;

  matrix_subsystem i_matrix_subsystem (.*);
  matrix_checker   i_checker (.*);

  initial
  begin
    HCLK = 1'b0;
    forever #20 HCLK = ~HCLK;   // 40 ns period
  end

  // ----------------------------------------------------------------------
  // Stimulus helpers
  // ----------------------------------------------------------------------
  // Galois LFSR, one step per bit taken
  function automatic logic [31:0] rand_bits(input int n);
    logic [31:0] v;
    v = '0;
    for (int i = 0; i < n; i++)
    begin
      v    = {v[30:0], lfsr[0]};
      lfsr = lfsr[0] ? ((lfsr >> 1) ^ 32'h8020_0003) : (lfsr >> 1);
    end
    return v;
  endfunction

  // Region on top, random filler in the bits nobody decodes
  function automatic matrix_pkg::addr_t make_addr(input logic [2:0] region,
                                                  input logic [3:0] idx);
    logic [18:0] mid;
    mid = 19'(rand_bits(19));
    return {region, mid, 4'h0, idx, 2'b00};
  endfunction

  // Wait for an edge with ready high, leaves 2 ns after that edge
  task automatic wait_ready(input int m);
    int   cnt;
    logic rdy;
    cnt = 0;
    rdy = 1'b0;
    while (!rdy && cnt < TIMEOUT)
    begin
      @(negedge HCLK);
      rdy = (m == 0) ? hreadyout_0 : hreadyout_1;
      @(posedge HCLK);
      cnt++;
    end
    #2;
    if (!rdy)
    begin
      $display("Manager %0d got no ready within %0d cycles at %0d ns", m, TIMEOUT, $time);
      tb_errors++;
    end
  endtask

  // Single NONSEQ transfer, address phase then data phase
  task automatic do_transfer(input int m, input matrix_pkg::addr_t a, input logic wr,
                             input matrix_pkg::data_t d);
    issued++;
    if (m == 0)
    begin
      haddr_0  = a;
      hwrite_0 = wr;
      htrans_0 = matrix_pkg::TRANS_NONSEQ;
    end
    else
    begin
      haddr_1  = a;
      hwrite_1 = wr;
      htrans_1 = matrix_pkg::TRANS_NONSEQ;
    end
    wait_ready(m);   // Held through any stall
    if (m == 0)
    begin
      htrans_0 = matrix_pkg::TRANS_IDLE;
      hwdata_0 = d;
    end
    else
    begin
      htrans_1 = matrix_pkg::TRANS_IDLE;
      hwdata_1 = d;
    end
    wait_ready(m);
  endtask

  task automatic xfer(input int m, input logic [2:0] region, input logic [3:0] idx,
                      input logic wr);
    matrix_pkg::addr_t a;
    matrix_pkg::data_t d;
    a = make_addr(region, idx);
    d = rand_bits(32);
    do_transfer(m, a, wr, d);
  endtask

  // Mapped regions mostly, about one in eight unmapped
  task automatic random_mix(input int m);
    logic [2:0] kind;
    logic [2:0] region;
    logic [3:0] idx;
    logic       wr;
    for (int i = 0; i < MIX_LEN; i++)
    begin
      kind = 3'(rand_bits(3));
      if (kind == 3'd0)
        region = 3'(3 + rand_bits(8) % 5);
      else
        region = 3'(rand_bits(8) % 3);
      idx = 4'(rand_bits(4));
      wr  = 1'(rand_bits(1));
      xfer(m, region, idx, wr);
    end
  endtask

  // ----------------------------------------------------------------------
  // Test sequence
  // ----------------------------------------------------------------------
  initial
  begin
    lfsr     = 32'h88b5_31f0;
    HRESETn  = 1'b0;
    haddr_0  = '0;
    htrans_0 = matrix_pkg::TRANS_IDLE;
    hwrite_0 = 1'b0;
    hwdata_0 = '0;
    haddr_1  = '0;
    htrans_1 = matrix_pkg::TRANS_IDLE;
    hwrite_1 = 1'b0;
    hwdata_1 = '0;
    repeat (16) @(posedge HCLK);
    #2;
    HRESETn = 1'b1;
    @(posedge HCLK);
    #2;

    // Fill every pool word, then read all back from manager 0
    for (int r = 0; r < 3; r++)
      for (int i = 0; i < POOL; i++)
        xfer(0, 3'(r), 4'(i), 1'b1);
    for (int r = 0; r < 3; r++)
      for (int i = 0; i < POOL; i++)
        xfer(0, 3'(r), 4'(i), 1'b0);

    // Unmapped regions 3..7, SRAM word at the same index must survive
    for (int k = 0; k < 10; k++)
    begin
      xfer(0, 3'(3 + k % 5), 4'(k), 1'b1);
      xfer(0, 3'(3 + k % 5), 4'(k), 1'b0);
      xfer(0, 3'(k % 3), 4'(k), 1'b0);
    end

    // Both managers on one subordinate
    for (int k = 0; k < 12; k++)
      fork
        xfer(0, 3'(k % 3), 4'(k), k[0]);
        xfer(1, 3'(k % 3), 4'(k + 1), !k[0]);
      join

    // Managers on different subordinates
    for (int k = 0; k < 12; k++)
      fork
        xfer(0, 3'(k % 3), 4'(k), k[1]);
        xfer(1, 3'((k + 1) % 3), 4'(k), !k[1]);
      join

    fork
      random_mix(0);
      random_mix(1);
    join

    if (i_checker.completed != issued)
    begin
      $display("Lost transfers, %0d issued but %0d completed", issued, i_checker.completed);
      tb_errors++;
    end
    $display("Summary: %0d transfers, %0d check errors, %0d driver errors",
             issued, i_checker.errors, tb_errors);
    if (i_checker.errors == 0 && tb_errors == 0)
      $display("No errors");
    else
      $display("Errors found");
    $finish;
  end

endmodule

// ==== project.f ====
common/matrix_pkg.sv
source/default_slave.sv
bus_matrix/bus_decoder.sv
bus_matrix/output_stage.sv
source/sram_slave.sv
source/matrix_subsystem.sv
dv/matrix_checker.sv
dv/tb_matrix_subsystem.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the bus matrix testbench with Verilator, then judge the log
cd "$(dirname "$0")" || exit 1
verilator --binary -Wno-fatal --top-module tb_matrix_subsystem -f project.f > build.log 2>&1 \
  && ./obj_dir/Vtb_matrix_subsystem > sim.log 2>&1 \
  || { cat build.log; echo "Build or simulation did not complete"; exit 1; }
cat sim.log
grep -q "Errors found" sim.log && exit 1 || exit 0

// ==== source/default_slave.sv ====
// Default subordinate giving the two-cycle AHB ERROR response to unmapped accesses
module default_slave (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  logic                hsel,
  input  matrix_pkg::trans_t  htrans,
  input  logic                hready,
  output logic                hreadyout,
  output matrix_pkg::resp_t   hresp
);

  matrix_pkg::dflt_state_e state;
  matrix_pkg::dflt_state_e state_nxt;
  logic take;   // Accepted NONSEQ to this port

  assign take = hsel && htrans[1] && hready;

  always_comb
  begin
    state_nxt = state;
    case (state)
      matrix_pkg::IDLE: if (take) state_nxt = matrix_pkg::ERR1;
      matrix_pkg::ERR1: state_nxt = matrix_pkg::ERR2;
      matrix_pkg::ERR2:
      begin
        // Back-to-back unmapped access restarts the response
        if (take)
          state_nxt = matrix_pkg::ERR1;
        else
          state_nxt = matrix_pkg::IDLE;
      end
      default: state_nxt = matrix_pkg::IDLE;
    endcase
  end

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
      state <= matrix_pkg::IDLE;
    else
      state <= state_nxt;
  end

  // Ready low only in the first ERROR cycle
  assign hreadyout = (state != matrix_pkg::ERR1);
  assign hresp     = (state == matrix_pkg::IDLE) ? matrix_pkg::RESP_OKAY
                                                 : matrix_pkg::RESP_ERROR;

endmodule

// ==== source/matrix_subsystem.sv ====
// AHB-Lite bus matrix top with two managers and three SRAM subordinates
module matrix_subsystem (
  input  logic                HCLK,
  input  logic                HRESETn,
  // Manager 0
  input  matrix_pkg::addr_t   haddr_0,
  input  matrix_pkg::trans_t  htrans_0,
  input  logic                hwrite_0,
  input  matrix_pkg::data_t   hwdata_0,
  output logic                hreadyout_0,
  output matrix_pkg::resp_t   hresp_0,
  output matrix_pkg::data_t   hrdata_0,
  // Manager 1
  input  matrix_pkg::addr_t   haddr_1,
  input  matrix_pkg::trans_t  htrans_1,
  input  logic                hwrite_1,
  input  matrix_pkg::data_t   hwdata_1,
  output logic                hreadyout_1,
  output matrix_pkg::resp_t   hresp_1,
  output matrix_pkg::data_t   hrdata_1
);

  localparam int NS = matrix_pkg::NUM_SUBS;

  logic [NS-1:0] sel_m0;        // Requests from manager 0 per subordinate
  logic [NS-1:0] sel_m1;
  logic [NS-1:0] act_m0;        // Accepts back to manager 0
  logic [NS-1:0] act_m1;
  logic [NS-1:0] sub_ready;
  logic [NS-1:0] sub_hsel;
  logic [NS-1:0] sub_hwrite;
  matrix_pkg::data_t  sub_rdata  [NS];
  matrix_pkg::addr_t  sub_haddr  [NS];
  matrix_pkg::trans_t sub_htrans [NS];
  matrix_pkg::data_t  sub_hwdata [NS];

  // ----------------------------------------------------------------------
  // Manager side decoders, ready fed back as HREADYS
  // ----------------------------------------------------------------------
  bus_decoder u_dec0 (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .haddr (haddr_0), .htrans (htrans_0), .hreadys (hreadyout_0),
    .sel_dec0 (sel_m0[0]), .sel_dec1 (sel_m0[1]), .sel_dec2 (sel_m0[2]),
    .active0 (act_m0[0]), .active1 (act_m0[1]), .active2 (act_m0[2]),
    .readyout0 (sub_ready[0]), .readyout1 (sub_ready[1]), .readyout2 (sub_ready[2]),
    .resp0 (matrix_pkg::RESP_OKAY), .resp1 (matrix_pkg::RESP_OKAY),
    .resp2 (matrix_pkg::RESP_OKAY),   // SRAMs never signal ERROR
    .rdata0 (sub_rdata[0]), .rdata1 (sub_rdata[1]), .rdata2 (sub_rdata[2]),
    .hreadyouts (hreadyout_0), .hresps (hresp_0), .hrdatas (hrdata_0)
  );

  bus_decoder u_dec1 (
    .HCLK (HCLK), .HRESETn (HRESETn),
    .haddr (haddr_1), .htrans (htrans_1), .hreadys (hreadyout_1),
    .sel_dec0 (sel_m1[0]), .sel_dec1 (sel_m1[1]), .sel_dec2 (sel_m1[2]),
    .active0 (act_m1[0]), .active1 (act_m1[1]), .active2 (act_m1[2]),
    .readyout0 (sub_ready[0]), .readyout1 (sub_ready[1]), .readyout2 (sub_ready[2]),
    .resp0 (matrix_pkg::RESP_OKAY), .resp1 (matrix_pkg::RESP_OKAY),
    .resp2 (matrix_pkg::RESP_OKAY),
    .rdata0 (sub_rdata[0]), .rdata1 (sub_rdata[1]), .rdata2 (sub_rdata[2]),
    .hreadyouts (hreadyout_1), .hresps (hresp_1), .hrdatas (hrdata_1)
  );

  // ----------------------------------------------------------------------
  // One output stage and SRAM per region
  // ----------------------------------------------------------------------
  for (genvar n = 0; n < NS; n++)
  begin : g_sub
    output_stage u_out (
      .HCLK (HCLK), .HRESETn (HRESETn),
      .req0 (sel_m0[n]), .req1 (sel_m1[n]),
      .haddr0 (haddr_0), .haddr1 (haddr_1),
      .hwrite0 (hwrite_0), .hwrite1 (hwrite_1),
      .hwdata0 (hwdata_0), .hwdata1 (hwdata_1),
      .hreadyout_sub (sub_ready[n]),
      .active0 (act_m0[n]), .active1 (act_m1[n]),
      .hsel (sub_hsel[n]), .haddr (sub_haddr[n]), .htrans (sub_htrans[n]),
      .hwrite (sub_hwrite[n]), .hwdata (sub_hwdata[n])
    );

    sram_slave #(
      .WAIT_STATES ((n == 0) ? matrix_pkg::WAIT_S0 :
                    (n == 1) ? matrix_pkg::WAIT_S1 : matrix_pkg::WAIT_S2)
    ) u_sram (
      .HCLK (HCLK), .HRESETn (HRESETn),
      .hsel (sub_hsel[n]), .haddr (sub_haddr[n]), .htrans (sub_htrans[n]),
      .hwrite (sub_hwrite[n]), .hwdata (sub_hwdata[n]),
      .hreadyout (sub_ready[n]), .hrdata (sub_rdata[n])
    );
  end

endmodule

// ==== source/sram_slave.sv ====
// Word SRAM subordinate with a fixed number of wait states per transfer
module sram_slave #(
  parameter int WAIT_STATES = 0
) (
  input  logic                HCLK,
  input  logic                HRESETn,
  input  logic                hsel,
  input  matrix_pkg::addr_t   haddr,
  input  matrix_pkg::trans_t  htrans,
  input  logic                hwrite,
  input  matrix_pkg::data_t   hwdata,
  output logic                hreadyout,
  output matrix_pkg::data_t   hrdata
);

  localparam int IDX_W = $clog2(matrix_pkg::SRAM_WORDS);
  localparam int CNT_W = (WAIT_STATES > 0) ? $clog2(WAIT_STATES + 1) : 1;

  matrix_pkg::data_t mem [matrix_pkg::SRAM_WORDS];

  logic             accept;      // Address phase taken this cycle
  logic             pend;        // Data phase in progress
  logic [CNT_W-1:0] wait_cnt;    // Wait states left
  logic             pend_write;
  logic [IDX_W-1:0] pend_idx;

  assign accept    = hsel && htrans[1] && hreadyout;
  assign hreadyout = (wait_cnt == '0);

  always_ff @(posedge HCLK)
  begin
    if (!HRESETn)
    begin
      pend     <= 1'b0;
      wait_cnt <= '0;
    end
    else if (hreadyout)
    begin
      pend <= accept;
      if (accept)
        wait_cnt <= CNT_W'(WAIT_STATES);
    end
    else
      wait_cnt <= wait_cnt - 1'b1;
  end

  // Registered address phase
  always_ff @(posedge HCLK)
  begin
    if (accept)
    begin
      pend_write <= hwrite;
      pend_idx   <= haddr[IDX_W+1:2];
    end
  end

  // Array update on the last data-phase edge
  always_ff @(posedge HCLK)
  begin
    if (pend && pend_write && hreadyout)
      mem[pend_idx] <= hwdata;
  end

  assign hrdata = mem[pend_idx];   // Valid once hreadyout rises

endmodule
